// File: Bender.yml
package:
  name: dz_game

sources:
  - hdl/dz_pkg.sv
  - hdl/scan_tick.sv
  - hdl/stage_ctrl.sv
  - hdl/glyph_rom.sv
  - hdl/dz_show.sv
  - hdl/dz_game_top.sv
  - target: simulation
    files:
      - bench/dz_game_sva.sv
      - bench/tb_dz_game.sv

// File: bench/dz_game_sva.sv
module dz_game_sva (
    input logic                     clk,
    input logic                     st,
    input logic                     tick,
    input logic                     fail,
    input dz_pkg::pic_t             dz_num,
    input logic [dz_pkg::COL_W-1:0] row,
    input logic [dz_pkg::COL_W-1:0] red
);

    import dz_pkg::*;

    logic ticked;        // first tick seen since reset
    int   fail_cnt = 0;  // assertion failures so far

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
            ticked <= 1'b0;
        else if (tick)
            ticked <= 1'b1;
    end

    a_row_onehot: assert property (@(posedge clk) disable iff (!st)
        ticked |-> $onehot(~row))
        else
        begin
            $error("row select not one-hot active low: %b", row);
            fail_cnt++;
        end

    // row_count steps on the tick edge, row follows one edge later
    a_row_step: assert property (@(posedge clk) disable iff (!st)
        ($changed(row) && $past(row) != '1) |-> $past(tick, 2))
        else
        begin
            $error("row changed without a tick before it");
            fail_cnt++;
        end

    a_fail_red: assert property (@(posedge clk) disable iff (!st)
        (fail && dz_num <= PIC_SEED5) |-> red == '0)
        else
        begin
            $error("red lit on a growth picture with fail set");
            fail_cnt++;
        end

endmodule

bind dz_show dz_game_sva u_sva (
    .clk    (clk),
    .st     (st),
    .tick   (tick),
    .fail   (fail),
    .dz_num (dz_num),
    .row    (row),
    .red    (red)
);

// File: bench/tb_dz_game.sv
module tb_dz_game;

    import dz_pkg::*;

    localparam int TICK_DIV = 4;
    localparam int DRV      = 5;                 // input delay after rising edge
    localparam int FRAME    = 8 * TICK_DIV + 4;  // a bit more than one full scan

    logic       clk;
    logic       st;
    logic       feed;
    logic       miss;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    int    n_edge;   // edges since reset release
    int    settle;   // column checks held off after a strobe
    int    err_cnt;
    int    to_cnt;
    game_t m_state;
    pic_t  m_pic;
    logic  m_fail;

    dz_game_top #(
        .TICK_DIV (TICK_DIV)
    ) uut (
        .clk  (clk),
        .st   (st),
        .feed (feed),
        .miss (miss),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk or negedge st)
    begin
        if (!st)
            n_edge <= 0;
        else
            n_edge <= n_edge + 1;
    end

    // row 0 in the top byte
    function automatic logic [7:0] model_green(pic_t p, int r);
        logic [63:0] bm;
        case (p)
            PIC_SEED0:  bm = 64'h0000_183C_3C18_0000;
            PIC_SEED1:  bm = 64'h0000_387C_7C38_0000;
            PIC_SEED2:  bm = 64'h0000_3C7E_7E3C_0000;
            PIC_SEED3:  bm = 64'h003C_7E7E_7E7E_3C00;
            PIC_SEED4:  bm = 64'h3C7E_FFFF_FFFF_7E3C;
            PIC_SEED5:  bm = 64'hFFFF_FFFF_FFFF_FFFF;
            PIC_BUD:    bm = 64'hC3E3_F1E3_C7E7_F7FB;
            PIC_LEAF:   bm = 64'h0001_81C3_83C7_E7F3;
            PIC_FLOWER: bm = 64'h0000_60FC_3F3E_1C00;
            PIC_FRUIT:  bm = 64'h0000_183C_7E7E_2400;
            default:    bm = '0;
        endcase
        return bm[63 - 8 * r -: 8];
    endfunction

    function automatic logic [7:0] model_red(pic_t p, int r, logic f);
        logic [63:0] bm;
        if (p == PIC_WILT)
            bm = 64'h0038_445A_4A32_C438;
        else if (p == PIC_HARVEST)
            bm = 64'hE060_E030_3133_3E1C;
        else if (p == PIC_BUD || p == PIC_LEAF || p == PIC_FLOWER)
            return model_green(p, r);
        else if (p <= PIC_SEED5 && !f)
            return model_green(p, r);  // yellow while healthy
        else
            bm = '0;
        return bm[63 - 8 * r -: 8];
    endfunction

    function automatic int row_index(logic [7:0] r);
        int k;
        row_index = -1;
        for (k = 0; k < 8; k++)
            if (r == ~(8'h01 << k))
                row_index = k;
    endfunction

    task automatic model_step(input logic f, input logic m);
        if (m_state == GROW && m && m_fail)
        begin
            m_state = WILT;
            m_pic   = PIC_WILT;
        end
        else if (m_state == GROW && m)
            m_fail = 1'b1;
        else if (m_state == GROW && f && m_pic == PIC_SEED5)
        begin
            m_state = BLOOM;
            m_pic   = PIC_BUD;
        end
        else if (m_state == GROW && f)
            m_pic = pic_t'(m_pic + 1);
        else if (m_state == BLOOM && m)
        begin
            m_state = WILT;
            m_pic   = PIC_WILT;
        end
        else if (m_state == BLOOM && f)
            case (m_pic)
                PIC_BUD:    m_pic = PIC_LEAF;
                PIC_LEAF:   m_pic = PIC_FLOWER;
                PIC_FLOWER: m_pic = PIC_FRUIT;
                default:
                begin
                    m_state = DONE;
                    m_pic   = PIC_HARVEST;
                end
            endcase
    endtask

    task automatic value_error(input string name, input logic [7:0] exp, input logic [7:0] got);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
        err_cnt++;
    endtask

    task automatic check_outputs();
        int         idx;
        logic [7:0] exp_row;
        logic [7:0] exp_g;
        logic [7:0] exp_r;
        // tick after TICK_DIV clocks, row_count on the tick edge, row one edge later
        idx     = (n_edge < 2) ? 0 : ((n_edge - 2) / TICK_DIV) % 8;
        exp_row = ~(8'h01 << idx);
        assert (row === exp_row) else value_error("row", exp_row, row);
        if (settle != 0)
            settle--;
        else
        begin
            exp_g = model_green(m_pic, idx);
            exp_r = model_red(m_pic, idx, m_fail);
            assert (colg === exp_g) else value_error("colg", exp_g, colg);
            assert (colr === exp_r) else value_error("colr", exp_r, colr);
        end
    endtask

    task automatic run_cycle(input logic f, input logic m);
        @(posedge clk);
        #DRV;
        feed = f;
        miss = m;
        if (f || m)
        begin
            model_step(f, m);
            settle = 3;
        end
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle(input int n);
        int k;
        for (k = 0; k < n; k++)
            run_cycle(1'b0, 1'b0);
    endtask

    task automatic apply_reset();
        int k;
        @(posedge clk);
        #DRV;
        st      = 1'b0;
        feed    = 1'b0;
        miss    = 1'b0;
        m_state = GROW;
        m_pic   = PIC_SEED0;
        m_fail  = 1'b0;
        settle  = 0;
        for (k = 0; k < 8; k++)
        begin
            @(negedge clk);
            assert (row === 8'hFF) else value_error("row", 8'hFF, row);
            assert (colr === 8'h00) else value_error("colr", 8'h00, colr);
            assert (colg === 8'h00) else value_error("colg", 8'h00, colg);
            @(posedge clk);
        end
        #DRV;
        st = 1'b1;
    endtask

    task automatic wait_first_tick();
        int cnt;
        cnt = 0;
        while (uut.tick !== 1'b1 && cnt < 4 * TICK_DIV)
        begin
            run_cycle(1'b0, 1'b0);
            cnt++;
        end
        if (uut.tick !== 1'b1)
        begin
            $display("Timeout: the scan tick never pulsed after reset");
            to_cnt++;
        end
        else
            assert (cnt == TICK_DIV) else
            begin
                $display("** Error at %0t: first tick expected after %0d clocks, got %0d",
                         $time, TICK_DIV, cnt);
                err_cnt++;
            end
    endtask

    task automatic wait_row_step(inout int idx);
        int cnt;
        cnt = 0;
        while (row_index(row) == idx && cnt < 2 * TICK_DIV)
        begin
            run_cycle(1'b0, 1'b0);
            cnt++;
        end
        if (row_index(row) == idx)
        begin
            $display("Timeout: row %0d was never followed by the next row", idx);
            to_cnt++;
        end
        else
        begin
            assert (row_index(row) == (idx + 1) % 8) else
                value_error("row", ~(8'h01 << ((idx + 1) % 8)), row);
            idx = row_index(row);
        end
    endtask

    initial
    begin
        int idx;
        int i;
        int round;
        st      = 1'b0;
        feed    = 1'b0;
        miss    = 1'b0;
        err_cnt = 0;
        to_cnt  = 0;
        settle  = 0;
        void'($urandom(85));
        apply_reset();
        wait_first_tick();
        idx = row_index(row);
        assert (idx == 0) else value_error("row", 8'hFE, row);
        for (i = 0; i < 9; i++)
            wait_row_step(idx);  // eight steps plus the wrap
        for (i = 0; i < 6; i++)
        begin
            idle(FRAME);
            run_cycle(1'b1, 1'b0);
        end
        idle(FRAME);
        apply_reset();
        run_cycle(1'b0, 1'b1);  // fail set, red goes dark
        for (i = 0; i < 10; i++)
        begin
            idle(FRAME);
            run_cycle(1'b1, 1'b0);
        end
        idle(FRAME);
        run_cycle(1'b0, 1'b1);
        run_cycle(1'b1, 1'b0);
        idle(FRAME);
        apply_reset();
        run_cycle(1'b1, 1'b0);
        run_cycle(1'b0, 1'b1);
        idle(FRAME);
        run_cycle(1'b0, 1'b1);  // wilt
        idle(FRAME);
        run_cycle(1'b1, 1'b1);
        idle(FRAME);
        for (round = 0; round < 2; round++)
        begin
            apply_reset();
            for (i = 0; i < 250; i++)
                run_cycle(($urandom % 12) == 0, ($urandom % 60) == 0);
        end
        $display("value errors: %0d, assertion failures: %0d, timeouts: %0d",
                 err_cnt, uut.u_show.u_sva.fail_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0 && uut.u_show.u_sva.fail_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: flist.f
hdl/dz_pkg.sv
hdl/scan_tick.sv
hdl/stage_ctrl.sv
hdl/glyph_rom.sv
hdl/dz_show.sv
hdl/dz_game_top.sv
bench/dz_game_sva.sv
bench/tb_dz_game.sv

// File: hdl/dz_game_top.sv
module dz_game_top #(
    parameter int TICK_DIV = 4
) (
    input  logic                     clk,
    input  logic                     st,
    input  logic                     feed,
    input  logic                     miss,
    output logic [dz_pkg::COL_W-1:0] row,
    output logic [dz_pkg::COL_W-1:0] colr,
    output logic [dz_pkg::COL_W-1:0] colg
);

    import dz_pkg::*;

    logic tick;
    pic_t pic;
    logic fail;

    scan_tick #(
        .TICK_DIV (TICK_DIV)
    ) u_tick (
        .clk  (clk),
        .st   (st),
        .tick (tick)
    );

    stage_ctrl u_ctrl (
        .clk  (clk),
        .st   (st),
        .feed (feed),
        .miss (miss),
        .pic  (pic),
        .fail (fail)
    );

    dz_show u_show (
        .clk  (clk),
        .st   (st),
        .tick (tick),
        .fail (fail),
        .pic  (pic),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

endmodule

// File: hdl/dz_pkg.sv
package dz_pkg;

    // matrix geometry
    localparam int ROW_W = 3;
    localparam int COL_W = 8;

    // picture codes shown on the matrix
    typedef enum logic [3:0] {
        PIC_SEED0   = 4'd0,     // growth stages
        PIC_SEED1   = 4'd1,
        PIC_SEED2   = 4'd2,
        PIC_SEED3   = 4'd3,
        PIC_SEED4   = 4'd4,
        PIC_SEED5   = 4'd5,
        PIC_BUD     = 4'd6,     // bloom pictures
        PIC_LEAF    = 4'd7,
        PIC_WILT    = 4'd8,     // red wilted plant
        PIC_FLOWER  = 4'd9,
        PIC_FRUIT   = 4'd10,
        PIC_HARVEST = 4'd11     // red basket
    } pic_t;
    // 12..15 left unused, they show dark

    // game controller states
    typedef enum logic [1:0] {
        GROW  = 2'd0,
        BLOOM = 2'd1,
        WILT  = 2'd2,
        DONE  = 2'd3
    } game_t;

endpackage

// File: hdl/dz_show.sv
module dz_show (
    input  logic                     clk,
    input  logic                     st,
    input  logic                     tick,
    input  logic                     fail,
    input  dz_pkg::pic_t             pic,
    output logic [dz_pkg::COL_W-1:0] row,
    output logic [dz_pkg::COL_W-1:0] colr,
    output logic [dz_pkg::COL_W-1:0] colg
);

    import dz_pkg::*;

    pic_t             dz_num;
    logic [ROW_W-1:0] row_count;
    logic [COL_W-1:0] green;
    logic [COL_W-1:0] red;

    // picture latch
    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
            dz_num <= PIC_SEED0;
        else
            dz_num <= pic;
    end

    // row scan, wraps 7 -> 0
    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
            row_count <= '0;
        else if (tick)
            row_count <= row_count + 1'b1;
    end

    glyph_rom u_rom (
        .pic     (dz_num),
        .row_idx (row_count),
        .fail    (fail),
        .green   (green),
        .red     (red)
    );

    // row select and columns move together
    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            row  <= '1;  // all rows off
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ~(COL_W'(1) << row_count);
            colr <= red;
            colg <= green;
        end
    end

endmodule

// File: hdl/glyph_rom.sv
module glyph_rom (
    input  dz_pkg::pic_t             pic,
    input  logic [dz_pkg::ROW_W-1:0] row_idx,
    input  logic                     fail,
    output logic [dz_pkg::COL_W-1:0] green,
    output logic [dz_pkg::COL_W-1:0] red
);

    import dz_pkg::*;

    logic [COL_W-1:0] green_map;
    logic [COL_W-1:0] red_map;

    // green bitmaps of growth and bloom pictures
    always_comb
    begin
        green_map = '0;
        case (pic)
            PIC_SEED0:
                case (row_idx)
                    3'd2, 3'd5: green_map = 8'b0001_1000;
                    3'd3, 3'd4: green_map = 8'b0011_1100;
                    default:    green_map = '0;
                endcase
            PIC_SEED1:
                case (row_idx)
                    3'd2, 3'd5: green_map = 8'b0011_1000;
                    3'd3, 3'd4: green_map = 8'b0111_1100;
                    default:    green_map = '0;
                endcase
            PIC_SEED2:
                case (row_idx)
                    3'd2, 3'd5: green_map = 8'b0011_1100;
                    3'd3, 3'd4: green_map = 8'b0111_1110;
                    default:    green_map = '0;
                endcase
            PIC_SEED3:
                case (row_idx)
                    3'd1, 3'd6:             green_map = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: green_map = 8'b0111_1110;
                    default:                green_map = '0;
                endcase
            PIC_SEED4:
                case (row_idx)
                    3'd0, 3'd7: green_map = 8'b0011_1100;
                    3'd1, 3'd6: green_map = 8'b0111_1110;
                    default:    green_map = 8'b1111_1111;
                endcase
            PIC_SEED5:
                green_map = 8'b1111_1111;  // full square
            PIC_BUD:
                case (row_idx)
                    3'd0:    green_map = 8'b1100_0011;
                    3'd1:    green_map = 8'b1110_0011;
                    3'd2:    green_map = 8'b1111_0001;
                    3'd3:    green_map = 8'b1110_0011;
                    3'd4:    green_map = 8'b1100_0111;
                    3'd5:    green_map = 8'b1110_0111;
                    3'd6:    green_map = 8'b1111_0111;
                    default: green_map = 8'b1111_1011;
                endcase
            PIC_LEAF:
                case (row_idx)
                    3'd1:    green_map = 8'b0000_0001;
                    3'd2:    green_map = 8'b1000_0001;
                    3'd3:    green_map = 8'b1100_0011;
                    3'd4:    green_map = 8'b1000_0011;
                    3'd5:    green_map = 8'b1100_0111;
                    3'd6:    green_map = 8'b1110_0111;
                    3'd7:    green_map = 8'b1111_0011;
                    default: green_map = '0;
                endcase
            PIC_FLOWER:
                case (row_idx)
                    3'd2:    green_map = 8'b0110_0000;
                    3'd3:    green_map = 8'b1111_1100;
                    3'd4:    green_map = 8'b0011_1111;
                    3'd5:    green_map = 8'b0011_1110;
                    3'd6:    green_map = 8'b0001_1100;
                    default: green_map = '0;
                endcase
            PIC_FRUIT:
                case (row_idx)
                    3'd2:       green_map = 8'b0001_1000;
                    3'd3:       green_map = 8'b0011_1100;
                    3'd4, 3'd5: green_map = 8'b0111_1110;
                    3'd6:       green_map = 8'b0010_0100;
                    default:    green_map = '0;
                endcase
            default:
                green_map = '0;  // wilt, harvest, unused
        endcase
    end

    // red-only pictures
    always_comb
    begin
        red_map = '0;
        if (pic == PIC_WILT)
        begin
            case (row_idx)
                3'd1:    red_map = 8'b0011_1000;
                3'd2:    red_map = 8'b0100_0100;
                3'd3:    red_map = 8'b0101_1010;
                3'd4:    red_map = 8'b0100_1010;
                3'd5:    red_map = 8'b0011_0010;
                3'd6:    red_map = 8'b1100_0100;
                3'd7:    red_map = 8'b0011_1000;
                default: red_map = '0;
            endcase
        end
        else if (pic == PIC_HARVEST)
        begin
            case (row_idx)
                3'd0:    red_map = 8'b1110_0000;
                3'd1:    red_map = 8'b0110_0000;
                3'd2:    red_map = 8'b1110_0000;
                3'd3:    red_map = 8'b0011_0000;
                3'd4:    red_map = 8'b0011_0001;
                3'd5:    red_map = 8'b0011_0011;
                3'd6:    red_map = 8'b0011_1110;
                default: red_map = 8'b0001_1100;
            endcase
        end
    end

    // colour rule, yellow unless the plant has failed
    always_comb
    begin
        green = green_map;
        case (pic)
            PIC_WILT, PIC_HARVEST:           red = red_map;
            PIC_BUD, PIC_LEAF, PIC_FLOWER:   red = green_map;
            PIC_SEED0, PIC_SEED1, PIC_SEED2,
            PIC_SEED3, PIC_SEED4, PIC_SEED5: red = fail ? '0 : green_map;
            default:                         red = '0;  // fruit stays green
        endcase
    end

endmodule

// File: hdl/scan_tick.sv
module scan_tick #(
    parameter int TICK_DIV = 4
) (
    input  logic clk,
    input  logic st,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // down-counter, one strobe per reload
    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            cnt  <= CNT_W'(TICK_DIV - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= CNT_W'(TICK_DIV - 1);
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// File: hdl/stage_ctrl.sv
module stage_ctrl (
    input  logic         clk,
    input  logic         st,
    input  logic         feed,
    input  logic         miss,
    output dz_pkg::pic_t pic,
    output logic         fail
);

    import dz_pkg::*;

    game_t state;
    game_t state_nx;
    pic_t  pic_nx;
    logic  fail_nx;

    always_comb
    begin
        state_nx = state;
        pic_nx   = pic;
        fail_nx  = fail;
        case (state)
            GROW:
            begin
                if (miss)
                begin
                    if (fail)
                    begin
                        // second miss kills the plant
                        state_nx = WILT;
                        pic_nx   = PIC_WILT;
                    end
                    else
                    begin
                        fail_nx = 1'b1;  // plant keeps growing
                    end
                end
                else if (feed)
                begin
                    if (pic == PIC_SEED5)
                    begin
                        state_nx = BLOOM;
                        pic_nx   = PIC_BUD;
                    end
                    else
                    begin
                        pic_nx = pic_t'(pic + 4'd1);
                    end
                end
            end
            BLOOM:
            begin
                if (miss)
                begin
                    state_nx = WILT;
                    pic_nx   = PIC_WILT;
                end
                else if (feed)
                begin
                    case (pic)
                        PIC_BUD:    pic_nx = PIC_LEAF;
                        PIC_LEAF:   pic_nx = PIC_FLOWER;  // code 8 is the wilt picture
                        PIC_FLOWER: pic_nx = PIC_FRUIT;
                        default:
                        begin
                            state_nx = DONE;
                            pic_nx   = PIC_HARVEST;
                        end
                    endcase
                end
            end
            default:
            begin
                state_nx = state;  // WILT and DONE wait for reset
            end
        endcase
    end

    always_ff @(posedge clk or negedge st)
    begin
        if (!st)
        begin
            state <= GROW;
            pic   <= PIC_SEED0;
            fail  <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            pic   <= pic_nx;
            fail  <= fail_nx;
        end
    end

endmodule
